// File: hw/isa_pkg.sv
/* Instruction set of the 16-bit accumulator processor: word types, opcodes and the
   memory word that is read either as an instruction or as data */
package isa_pkg;

    localparam int DATA_W = 16;
    localparam int ADDR_W = 8;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // ------------------------------------------------------------------------
    // Instruction classes, top three opcode bits
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        CLASS_XFER  = 3'b000,  // Data transfer
        CLASS_ARITH = 3'b001,
        CLASS_CTRL  = 3'b010,
        CLASS_IO    = 3'b011   // OUT lives here
    } op_class_e;

    // ------------------------------------------------------------------------
    // Opcodes: class, one zero bit, 4-bit sub-opcode
    // ------------------------------------------------------------------------
    typedef enum logic [7:0] {
        LDA = {CLASS_XFER, 1'b0, 4'b0000},
        STA = {CLASS_XFER, 1'b0, 4'b0001},

        ADD = {CLASS_ARITH, 1'b0, 4'b0000},
        SUB = {CLASS_ARITH, 1'b0, 4'b0001},
        CLR = {CLASS_ARITH, 1'b0, 4'b1110},

        BUN = {CLASS_CTRL, 1'b0, 4'b0000},  // Unconditional jump
        JZ  = {CLASS_CTRL, 1'b0, 4'b0001},
        JN  = {CLASS_CTRL, 1'b0, 4'b0010},
        INC = {CLASS_CTRL, 1'b0, 4'b0100},
        DEC = {CLASS_CTRL, 1'b0, 4'b0101},
        HLT = {CLASS_CTRL, 1'b0, 4'b1111},

        OUT = {CLASS_IO, 1'b0, 4'b0101}
    } opcode_e;

    // Single-word instruction, operand address in the low byte
    typedef struct packed {
        opcode_e opcode;
        addr_t   addr;
    } instr_t;

    // Same memory word seen as an instruction (IR) or as an operand (DR)
    typedef union packed {
        instr_t instr;
        word_t  data;
    } mem_word_u;

endpackage

// File: hw/ctrl_pkg.sv
/* Microarchitecture encodings shared by the control unit and the datapath */
package ctrl_pkg;

    // Fetch, decode, up to four execute steps, halt
    typedef enum logic [3:0] {
        FETCH_0,
        FETCH_1,
        FETCH_2,
        DECODE,
        EXEC_0,
        EXEC_1,
        EXEC_2,
        EXEC_3,
        HALT
    } state_e;

    // ------------------------------------------------------------------------
    // Internal bus source
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        BUS_IR_ADDR = 2'b00,  // Operand address field, zero extended
        BUS_AC      = 2'b01,
        BUS_MEM     = 2'b10,
        BUS_PC      = 2'b11
    } bus_src_e;

    // ALU operation, result goes to AC
    typedef enum logic [2:0] {
        ALU_PASS = 3'b000,  // AC <= DR
        ALU_ADD  = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_INC  = 3'b011,
        ALU_DEC  = 3'b100,
        ALU_CLR  = 3'b101
    } alu_op_e;

endpackage

// File: hw/cpu_if.sv
/* Control lines between control unit and datapath, and the processor side
   of the memory; the control unit only drives the write enable */
`timescale 1ns/1ps

interface ctrl_if;

    logic               ar_load;
    logic               pc_load;
    logic               pc_inc;
    logic               ir_load;
    logic               dr_load;
    logic               ac_load;
    ctrl_pkg::bus_src_e bus_src;
    ctrl_pkg::alu_op_e  alu_op;

    // Status back to the control unit
    isa_pkg::opcode_e   opcode;
    logic               ac_zero;
    logic               ac_neg;

    modport cu (
        output ar_load, pc_load, pc_inc, ir_load, dr_load, ac_load, bus_src, alu_op,
        input  opcode, ac_zero, ac_neg
    );

    modport dp (
        input  ar_load, pc_load, pc_inc, ir_load, dr_load, ac_load, bus_src, alu_op,
        output opcode, ac_zero, ac_neg
    );

endinterface

interface mem_if;

    isa_pkg::addr_t addr;   // From AR
    isa_pkg::word_t wdata;  // From AC
    logic           write;
    isa_pkg::word_t rdata;  // Registered, one cycle after addr

    modport cpu (output addr, wdata, input rdata);
    modport mem (input addr, wdata, write, output rdata);
    modport ctl (output write);

endinterface

// File: hw/control_unit.sv
/* Fetch, decode and execute FSM; one execute sequence per opcode, decoded
   from IR, drives the datapath loads, bus select, ALU op and memory write */
`timescale 1ns/1ps

module control_unit (
    input  logic     clk,
    input  logic     rst,
    input  logic     run,
    ctrl_if.cu       ctrl,
    mem_if.ctl       mem,
    output logic     out_valid,
    output logic     halted
);

    ctrl_pkg::state_e state;
    ctrl_pkg::state_e next_state;
    logic             mem_op;   // Opcode needs an operand access
    logic             take_jump;

    assign mem_op = ctrl.opcode inside {isa_pkg::LDA, isa_pkg::STA,
                                        isa_pkg::ADD, isa_pkg::SUB};

    always_comb begin
        case (ctrl.opcode)
            isa_pkg::BUN: take_jump = 1'b1;
            isa_pkg::JZ:  take_jump = ctrl.ac_zero;
            isa_pkg::JN:  take_jump = ctrl.ac_neg;
            default:      take_jump = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ctrl_pkg::FETCH_0;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ctrl_pkg::FETCH_0: if (run) next_state = ctrl_pkg::FETCH_1;
            ctrl_pkg::FETCH_1: next_state = ctrl_pkg::FETCH_2;
            ctrl_pkg::FETCH_2: next_state = ctrl_pkg::DECODE;
            ctrl_pkg::DECODE: begin
                case (ctrl.opcode)
                    isa_pkg::LDA, isa_pkg::STA, isa_pkg::ADD, isa_pkg::SUB,
                    isa_pkg::CLR, isa_pkg::INC, isa_pkg::DEC, isa_pkg::BUN,
                    isa_pkg::JZ,  isa_pkg::JN,  isa_pkg::OUT:
                        next_state = ctrl_pkg::EXEC_0;
                    default:
                        next_state = ctrl_pkg::HALT;  // HLT and unknown codes
                endcase
            end
            ctrl_pkg::EXEC_0: next_state = mem_op ? ctrl_pkg::EXEC_1 : ctrl_pkg::FETCH_0;
            ctrl_pkg::EXEC_1: begin
                // STA is done after its write
                if (ctrl.opcode == isa_pkg::STA) next_state = ctrl_pkg::FETCH_0;
                else                             next_state = ctrl_pkg::EXEC_2;
            end
            ctrl_pkg::EXEC_2: next_state = ctrl_pkg::EXEC_3;
            ctrl_pkg::EXEC_3: next_state = ctrl_pkg::FETCH_0;
            ctrl_pkg::HALT:   next_state = ctrl_pkg::HALT;  // Left only by reset
            default:          next_state = ctrl_pkg::FETCH_0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Control lines per state
    // ------------------------------------------------------------------------
    always_comb begin
        ctrl.ar_load = 1'b0;
        ctrl.pc_load = 1'b0;
        ctrl.pc_inc  = 1'b0;
        ctrl.ir_load = 1'b0;
        ctrl.dr_load = 1'b0;
        ctrl.ac_load = 1'b0;
        ctrl.bus_src = ctrl_pkg::BUS_PC;
        ctrl.alu_op  = ctrl_pkg::ALU_PASS;
        mem.write    = 1'b0;
        out_valid    = 1'b0;

        case (state)
            ctrl_pkg::FETCH_0: ctrl.ar_load = run;   // AR takes PC as fetch starts
            ctrl_pkg::FETCH_1: ctrl.pc_inc = 1'b1;   // Memory reads meanwhile
            ctrl_pkg::FETCH_2: begin
                ctrl.bus_src = ctrl_pkg::BUS_MEM;
                ctrl.ir_load = 1'b1;
            end
            ctrl_pkg::EXEC_0: begin
                ctrl.bus_src = ctrl_pkg::BUS_IR_ADDR;
                ctrl.ar_load = mem_op;
                ctrl.pc_load = take_jump;
                out_valid    = (ctrl.opcode == isa_pkg::OUT);
                case (ctrl.opcode)
                    isa_pkg::INC: ctrl.alu_op = ctrl_pkg::ALU_INC;
                    isa_pkg::DEC: ctrl.alu_op = ctrl_pkg::ALU_DEC;
                    isa_pkg::CLR: ctrl.alu_op = ctrl_pkg::ALU_CLR;
                    default:      ctrl.alu_op = ctrl_pkg::ALU_PASS;
                endcase
                ctrl.ac_load = ctrl.opcode inside {isa_pkg::INC, isa_pkg::DEC,
                                                   isa_pkg::CLR};
            end
            ctrl_pkg::EXEC_1: mem.write = (ctrl.opcode == isa_pkg::STA);
            ctrl_pkg::EXEC_2: begin
                ctrl.bus_src = ctrl_pkg::BUS_MEM;
                ctrl.dr_load = 1'b1;
            end
            ctrl_pkg::EXEC_3: begin
                ctrl.ac_load = 1'b1;
                if (ctrl.opcode == isa_pkg::ADD)      ctrl.alu_op = ctrl_pkg::ALU_ADD;
                else if (ctrl.opcode == isa_pkg::SUB) ctrl.alu_op = ctrl_pkg::ALU_SUB;
            end
            default: ;
        endcase
    end

    assign halted = (state == ctrl_pkg::HALT);

endmodule

// File: hw/datapath.sv
/* Processor registers, internal bus and ALU; follows the control lines from
   the control unit and returns the opcode and AC flags */
`timescale 1ns/1ps

module datapath (
    input  logic           clk,
    input  logic           rst,
    ctrl_if.dp             ctrl,
    mem_if.cpu             mem,
    output isa_pkg::word_t out_data
);

    isa_pkg::addr_t    ar;
    isa_pkg::addr_t    pc;
    isa_pkg::mem_word_u ir;   // Read as instruction
    isa_pkg::mem_word_u dr;   // Read as operand
    isa_pkg::word_t    ac;

    isa_pkg::word_t    bus;
    isa_pkg::word_t    alu_result;

    // ------------------------------------------------------------------------
    // Internal bus
    // ------------------------------------------------------------------------
    always_comb begin
        case (ctrl.bus_src)
            ctrl_pkg::BUS_PC:      bus = isa_pkg::word_t'(pc);
            ctrl_pkg::BUS_MEM:     bus = mem.rdata;
            ctrl_pkg::BUS_AC:      bus = ac;
            ctrl_pkg::BUS_IR_ADDR: bus = isa_pkg::word_t'(ir.instr.addr);
            default:               bus = '0;
        endcase
    end

    // ALU, one operand always AC
    always_comb begin
        case (ctrl.alu_op)
            ctrl_pkg::ALU_PASS: alu_result = dr.data;
            ctrl_pkg::ALU_ADD:  alu_result = ac + dr.data;  // Wraps mod 2^16
            ctrl_pkg::ALU_SUB:  alu_result = ac - dr.data;
            ctrl_pkg::ALU_INC:  alu_result = ac + isa_pkg::word_t'(1);
            ctrl_pkg::ALU_DEC:  alu_result = ac - isa_pkg::word_t'(1);
            ctrl_pkg::ALU_CLR:  alu_result = '0;
            default:            alu_result = ac;
        endcase
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
            ac <= '0;
        end else begin
            if (ctrl.pc_load) begin
                pc <= bus[isa_pkg::ADDR_W-1:0];
            end else if (ctrl.pc_inc) begin
                pc <= pc + isa_pkg::addr_t'(1);
            end
            if (ctrl.ac_load) begin
                ac <= alu_result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ar_load) ar <= bus[isa_pkg::ADDR_W-1:0];
        if (ctrl.ir_load) ir <= bus;
        if (ctrl.dr_load) dr <= bus;
    end

    // Status and memory side
    assign ctrl.opcode  = ir.instr.opcode;
    assign ctrl.ac_zero = (ac == '0);
    assign ctrl.ac_neg  = ac[isa_pkg::DATA_W-1];

    assign mem.addr  = ar;
    assign mem.wdata = ac;
    assign out_data  = ac;

endmodule

// File: hw/main_memory.sv
/* Word-addressed program and data memory with a registered read; the load
   port fills it before a run */
`timescale 1ns/1ps

module main_memory #(
    parameter int MEM_DEPTH = 256
) (
    input  logic           clk,
    mem_if.mem             mem,
    input  logic           load_en,
    input  isa_pkg::addr_t load_addr,
    input  isa_pkg::word_t load_data
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    isa_pkg::word_t   mem_array [MEM_DEPTH];
    logic [IDX_W-1:0] cpu_idx;
    logic [IDX_W-1:0] load_idx;

    // Addresses above the depth wrap
    assign cpu_idx  = mem.addr[IDX_W-1:0];
    assign load_idx = load_addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem_array[load_idx] <= load_data;  // Preload wins
        end else if (mem.write) begin
            mem_array[cpu_idx] <= mem.wdata;
        end
        mem.rdata <= mem_array[cpu_idx];
    end

endmodule

// File: hw/cpu_top.sv
/* Accumulator processor top level; memory is preloaded through the load port
   with run low, then run starts execution from address 0 */
`timescale 1ns/1ps

module cpu_top #(
    parameter int MEM_DEPTH = 256
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  logic           load_en,
    input  isa_pkg::addr_t load_addr,
    input  isa_pkg::word_t load_data,
    output logic           out_valid,
    output isa_pkg::word_t out_data,
    output logic           halted
);

    ctrl_if ctrl_bus ();
    mem_if  mem_bus ();

    // ------------------------------------------------------------------------
    // Processor
    // ------------------------------------------------------------------------
    control_unit control_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .ctrl      (ctrl_bus.cu),
        .mem       (mem_bus.ctl),
        .out_valid (out_valid),
        .halted    (halted)
    );

    datapath datapath_inst (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl_bus.dp),
        .mem      (mem_bus.cpu),
        .out_data (out_data)
    );

    // Memory
    main_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) main_memory_inst (
        .clk       (clk),
        .mem       (mem_bus.mem),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: verification/cpu_top_props.sv
/* Concurrent checks on the output strobe and the halt flag, bound into cpu_top */
`timescale 1ns/1ps

module cpu_top_props (
    input logic clk,
    input logic rst,
    input logic out_valid,
    input logic halted
);

    // No output once stopped
    out_not_when_halted: assert property (
        @(posedge clk) disable iff (rst) !(out_valid && halted)
    ) else $error("out_valid high while halted");

    halted_is_sticky: assert property (
        @(posedge clk) disable iff (rst) halted |=> halted
    ) else $error("halted dropped without a reset");

    // Strobe with no back-pressure
    out_valid_one_cycle: assert property (
        @(posedge clk) disable iff (rst) out_valid |=> !out_valid
    ) else $error("out_valid held longer than one cycle");

endmodule

bind cpu_top cpu_top_props cpu_top_props_inst (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .halted    (halted)
);

// File: verification/tb_cpu_top.sv
/* Testbench for the accumulator processor; runs every program of the stimulus
   file from reset, checks each output strobe in order and the final halt */
`timescale 1ns/1ps

module tb_cpu_top;

    localparam int    CLK_PERIOD  = 100;
    localparam int    DRIVE_DELAY = 10;
    localparam string STIM_FILE   = "verification/cpu_stimulus.txt";

    logic           clk;
    logic           rst;
    logic           run;
    logic           load_en;
    isa_pkg::addr_t load_addr;
    isa_pkg::word_t load_data;
    logic           out_valid;
    isa_pkg::word_t out_data;
    logic           halted;

    // Parsed stimulus, programs kept back to back
    isa_pkg::addr_t pre_addr_q[$];
    isa_pkg::word_t pre_data_q[$];
    isa_pkg::word_t exp_q[$];
    int             pre_count_q[$];   // Preload records per program
    int             exp_count_q[$];   // Expected outputs per program
    int             watchdog_cycles = 0;
    bit             verdict_done    = 1'b0;

    cpu_top #(
        .MEM_DEPTH (256)
    ) cpu_top_inst (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        verdict_done = 1'b1;
        $display("TEST FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_word(input string what, input isa_pkg::word_t got,
                              input isa_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: %s is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus file: P addr word, R, E word, H
    // ------------------------------------------------------------------------
    task automatic read_stimulus();
        int             fd;
        int             n;
        int             pre_n;
        int             exp_n;
        bit             seen_run;
        string          line;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        pre_n    = 0;
        exp_n    = 0;
        seen_run = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            fail_run({"cannot open the stimulus file ", STIM_FILE});
        end
        while ($fgets(line, fd) > 0) begin
            case (line.getc(0))
                "P": begin
                    n = $sscanf(line, "P %h %h", a, b);
                    if (n != 2 || seen_run) begin
                        fail_run("preload record is malformed or follows the run record");
                    end else begin
                        pre_addr_q.push_back(a[7:0]);
                        pre_data_q.push_back(b);
                        pre_n++;
                    end
                end
                "R": seen_run = 1'b1;
                "E": begin
                    n = $sscanf(line, "E %h", b);
                    if (n != 1 || !seen_run) begin
                        fail_run("expected output record is malformed or comes before run");
                    end else begin
                        exp_q.push_back(b);
                        exp_n++;
                    end
                end
                "H": begin
                    if (!seen_run) begin
                        fail_run("halt record found without a run record");
                    end else begin
                        pre_count_q.push_back(pre_n);
                        exp_count_q.push_back(exp_n);
                        pre_n    = 0;
                        exp_n    = 0;
                        seen_run = 1'b0;
                    end
                end
                default: ;  // Comment or blank line
            endcase
        end
        $fclose(fd);
        if (seen_run || pre_n != 0 || pre_count_q.size() == 0) begin
            fail_run("stimulus file does not end with a complete program");
        end
    endtask

    // Reset, preload with run low, run until halted
    task automatic run_program(input int prog, input int pre_first, input int pre_n,
                               input int exp_first, input int exp_n);
        int i;
        int got_n;
        got_n = 0;
        @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b1;
        run = 1'b0;
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        @(negedge clk);
        check_flag("halted after reset", halted, 1'b0);
        check_flag("out_valid after reset", out_valid, 1'b0);

        for (i = 0; i < pre_n; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            load_en   = 1'b1;
            load_addr = pre_addr_q[pre_first + i];
            load_data = pre_data_q[pre_first + i];
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        load_en = 1'b0;
        run     = 1'b1;

        // Mid-cycle sampling of the strobe
        do begin
            @(negedge clk);
            if (out_valid) begin
                if (got_n == exp_n) begin
                    fail_run($sformatf("program %0d gave more outputs than expected", prog));
                end else begin
                    check_word($sformatf("program %0d output %0d", prog, got_n),
                               out_data, exp_q[exp_first + got_n]);
                    got_n++;
                end
            end
        end while (!halted);

        if (got_n != exp_n) begin
            fail_run($sformatf("program %0d halted after %0d of %0d expected outputs",
                               prog, got_n, exp_n));
        end
        repeat (4) begin
            @(negedge clk);
            check_flag("halted after HLT", halted, 1'b1);
            check_flag("out_valid after HLT", out_valid, 1'b0);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        int pre_first;
        int exp_first;
        rst       = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        pre_first = 0;
        exp_first = 0;
        read_stimulus();
        watchdog_cycles = 12 * (exp_q.size() + pre_addr_q.size()) + 200;
        for (int p = 0; p < pre_count_q.size(); p++) begin
            run_program(p, pre_first, pre_count_q[p], exp_first, exp_count_q[p]);
            pre_first += pre_count_q[p];
            exp_first += exp_count_q[p];
        end
        verdict_done = 1'b1;
        $display("TEST PASS");
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        fail_run("watchdog expired, a program never halted");
    end

    // Run stopped by a failing assertion
    final begin
        if (!verdict_done) begin
            $display("TEST FAIL");
        end
    end

endmodule

// File: verification/cpu_stimulus.txt
# P addr word = preload, R = run, E word = expected output in order, H = end of program
# Hex values; an instruction is opcode byte then operand address byte
# Program 0: LDA, ADD, SUB, INC, STA then LDA of the same word
P 00 000B  LDA 0B
P 01 6500  OUT
P 02 200C  ADD 0C
P 03 6500  OUT
P 04 210B  SUB 0B
P 05 010D  STA 0D
P 06 4400  INC
P 07 6500  OUT
P 08 000D  LDA 0D
P 09 6500  OUT
P 0A 4F00  HLT
P 0B 1234
P 0C F000
P 0D 5A5A
R
E 1234
E 0234
E F001
E F000
H
# Program 1: DEC and JZ loop, JN both ways, CLR, BUN over an OUT
P 00 000F  LDA 0F
P 01 6500  OUT
P 02 4500  DEC
P 03 4105  JZ 05
P 04 4001  BUN 01
P 05 4208  JN 08
P 06 4500  DEC
P 07 4209  JN 09
P 08 6500  OUT
P 09 6500  OUT
P 0A 2E00  CLR
P 0B 400D  BUN 0D
P 0C 6500  OUT
P 0D 6500  OUT
P 0E 4F00  HLT
P 0F 0002
R
E 0002
E 0001
E FFFF
E 0000
H

// File: cpu_top.f
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/cpu_if.sv
hw/control_unit.sv
hw/datapath.sv
hw/main_memory.sv
hw/cpu_top.sv
verification/cpu_top_props.sv
verification/tb_cpu_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_cpu_top
FILELIST  := cpu_top.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@result="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
